//--- Makefile
# Verilator build for the ALU execute slice

SIM        = verilator
TOP        = alu_exec_tb
RTL_TOP    = alu_exec_top
FILELIST   = alu_exec_top.f
SIM_FLAGS  = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing
OBJ_DIR    = obj_dir
LOG        = sim.log
FAIL_MSG   = CHECKS FAILED
PASS_MSG   = ALL CHECKS PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(SIM) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "Simulation reported failures, see $(LOG)"; exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then \
	  echo "Simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- alu_exec_top.f
src/cpu_types_pkg.sv
src/alu.sv
src/register_file.sv
src/exec_pipeline.sv
src/alu_exec_top.sv
tb/alu_exec_tb.sv

//--- src/alu.sv
/*
  ALU
  Combinational 32-bit ALU with negative, overflow and zero flags
*/

`timescale 1ns/1ns

module alu (
  input  cpu_types_pkg::aluop_t     op,
  input  cpu_types_pkg::word_t      port_a,
  input  cpu_types_pkg::word_t      port_b,
  output cpu_types_pkg::word_t      result,
  output cpu_types_pkg::alu_flags_t flags
);

  localparam int MSB = cpu_types_pkg::WORD_W - 1;

  cpu_types_pkg::word_t sum;
  cpu_types_pkg::word_t diff;
  logic [4:0]           shamt;
  logic                 add_ovf;
  logic                 sub_ovf;
  logic                 lt_signed;
  logic                 lt_unsigned;

  assign sum   = port_a + port_b;
  assign diff  = port_a - port_b;
  assign shamt = port_b[4:0];

  // Same-sign operands whose sum flips sign
  assign add_ovf = (port_a[MSB] == port_b[MSB]) && (sum[MSB] != port_a[MSB]);

  // Mixed-sign operands whose difference leaves the sign of A
  assign sub_ovf = (port_a[MSB] != port_b[MSB]) && (diff[MSB] != port_a[MSB]);

  assign lt_signed   = $signed(port_a) < $signed(port_b);
  assign lt_unsigned = port_a < port_b;

  always_comb begin
    result         = '0;
    flags.overflow = 1'b0;
    case (op)
      cpu_types_pkg::ALU_SLL: begin
        result = port_a << shamt;
      end
      cpu_types_pkg::ALU_SRL: begin
        result = port_a >> shamt;
      end
      cpu_types_pkg::ALU_ADD: begin
        result         = sum;
        flags.overflow = add_ovf;
      end
      cpu_types_pkg::ALU_SUB: begin
        result         = diff;
        flags.overflow = sub_ovf;
      end
      cpu_types_pkg::ALU_AND: begin
        result = port_a & port_b;
      end
      cpu_types_pkg::ALU_OR: begin
        result = port_a | port_b;
      end
      cpu_types_pkg::ALU_XOR: begin
        result = port_a ^ port_b;
      end
      cpu_types_pkg::ALU_NOR: begin
        result = ~(port_a | port_b);
      end
      cpu_types_pkg::ALU_SLT: begin
        result = cpu_types_pkg::word_t'(lt_signed);
      end
      cpu_types_pkg::ALU_SLTU: begin
        result = cpu_types_pkg::word_t'(lt_unsigned);
      end
      default: begin
        // Unused encodings give zero
        result = '0;
      end
    endcase
    // Flags that follow the result alone
    flags.negative = result[MSB];
    flags.zero     = (result == '0);
  end

endmodule

//--- src/alu_exec_top.sv
/*
  ALU execute slice top level
  Connects the execute pipeline, register file and ALU
*/

`timescale 1ns/1ns

module alu_exec_top (
  input  logic                     CLK,
  input  logic                     reset,
  input  logic                     req_valid,
  output logic                     req_ready,
  input  cpu_types_pkg::exec_req_t req,
  output logic                     rsp_valid,
  input  logic                     rsp_ready,
  output cpu_types_pkg::exec_rsp_t rsp
);

  cpu_types_pkg::reg_addr_t  rs_addr;
  cpu_types_pkg::reg_addr_t  rt_addr;
  cpu_types_pkg::word_t      rs_data;
  cpu_types_pkg::word_t      rt_data;
  cpu_types_pkg::aluop_t     alu_op;
  cpu_types_pkg::word_t      alu_a;
  cpu_types_pkg::word_t      alu_b;
  cpu_types_pkg::word_t      alu_result;
  cpu_types_pkg::alu_flags_t alu_flags;
  logic                      wr_en;
  cpu_types_pkg::reg_addr_t  wr_addr;
  cpu_types_pkg::word_t      wr_data;

  exec_pipeline exec_pipeline_i (
    .CLK        (CLK),
    .reset      (reset),
    .req_valid  (req_valid),
    .req_ready  (req_ready),
    .req        (req),
    .rsp_valid  (rsp_valid),
    .rsp_ready  (rsp_ready),
    .rsp        (rsp),
    .rs_addr    (rs_addr),
    .rt_addr    (rt_addr),
    .rs_data    (rs_data),
    .rt_data    (rt_data),
    .alu_op     (alu_op),
    .alu_a      (alu_a),
    .alu_b      (alu_b),
    .alu_result (alu_result),
    .alu_flags  (alu_flags),
    .wr_en      (wr_en),
    .wr_addr    (wr_addr),
    .wr_data    (wr_data)
  );

  register_file register_file_i (
    .CLK     (CLK),
    .reset   (reset),
    .rs_addr (rs_addr),
    .rt_addr (rt_addr),
    .rs_data (rs_data),
    .rt_data (rt_data),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (wr_data)
  );

  alu alu_i (
    .op     (alu_op),
    .port_a (alu_a),
    .port_b (alu_b),
    .result (alu_result),
    .flags  (alu_flags)
  );

endmodule

//--- src/cpu_types_pkg.sv
/*
  CPU types package
  Word and register types, ALU opcodes and the request, response
  and flag structs shared by the execute slice
*/

package cpu_types_pkg;

  // Datapath widths
  localparam int WORD_W     = 32;
  localparam int REG_COUNT  = 32;
  localparam int REG_ADDR_W = $clog2(REG_COUNT);

  // Data word for operands, immediates and results
  typedef logic [WORD_W-1:0] word_t;

  // Register number
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;

  // ALU operations
  typedef enum logic [3:0] {
    ALU_SLL  = 4'd0,
    ALU_SRL  = 4'd1,
    ALU_ADD  = 4'd2,
    ALU_SUB  = 4'd3,
    ALU_AND  = 4'd4,
    ALU_OR   = 4'd5,
    ALU_XOR  = 4'd6,
    ALU_NOR  = 4'd7,
    ALU_SLT  = 4'd8,
    ALU_SLTU = 4'd9
  } aluop_t;

  // ALU status flags
  typedef struct packed {
    logic negative;
    logic overflow;
    logic zero;
  } alu_flags_t;

  // Operation request
  typedef struct packed {
    aluop_t    op;
    reg_addr_t rs;
    reg_addr_t rt;
    logic      use_imm;   // imm replaces rt as operand B
    word_t     imm;
    reg_addr_t rd;
  } exec_req_t;

  // Operation response
  typedef struct packed {
    word_t      result;
    reg_addr_t  rd;
    alu_flags_t flags;
  } exec_rsp_t;

endpackage

//--- src/exec_pipeline.sv
/*
  Execute pipeline
  Issue stage and response register with valid/ready flow control,
  operand selection and register writeback
*/

`timescale 1ns/1ns

module exec_pipeline (
  input  logic                      CLK,
  input  logic                      reset,

  // Request port
  input  logic                      req_valid,
  output logic                      req_ready,
  input  cpu_types_pkg::exec_req_t  req,

  // Response port
  output logic                      rsp_valid,
  input  logic                      rsp_ready,
  output cpu_types_pkg::exec_rsp_t  rsp,

  // Register file read
  output cpu_types_pkg::reg_addr_t  rs_addr,
  output cpu_types_pkg::reg_addr_t  rt_addr,
  input  cpu_types_pkg::word_t      rs_data,
  input  cpu_types_pkg::word_t      rt_data,

  // ALU
  output cpu_types_pkg::aluop_t     alu_op,
  output cpu_types_pkg::word_t      alu_a,
  output cpu_types_pkg::word_t      alu_b,
  input  cpu_types_pkg::word_t      alu_result,
  input  cpu_types_pkg::alu_flags_t alu_flags,

  // Register file write
  output logic                      wr_en,
  output cpu_types_pkg::reg_addr_t  wr_addr,
  output cpu_types_pkg::word_t      wr_data
);

  // Stage 1 holds the accepted request
  logic                     s1_valid;
  cpu_types_pkg::exec_req_t s1_req;

  // Response register
  logic                     rsp_valid_q;
  cpu_types_pkg::exec_rsp_t rsp_q;

  logic accept;
  logic advance;

  // Stage 1 moves on when the response slot is free or being emptied
  assign advance   = s1_valid && (!rsp_valid_q || rsp_ready);
  assign req_ready = !s1_valid || advance;
  assign accept    = req_valid && req_ready;

  always_ff @(posedge CLK) begin
    if (reset) begin
      s1_valid <= 1'b0;
    end else if (accept) begin
      s1_valid <= 1'b1;
    end else if (advance) begin
      s1_valid <= 1'b0;
    end
  end

  always_ff @(posedge CLK) begin
    if (accept) begin
      s1_req <= req;
    end
  end

  // Operand fetch and select
  assign rs_addr = s1_req.rs;
  assign rt_addr = s1_req.rt;
  assign alu_op  = s1_req.op;
  assign alu_a   = rs_data;
  assign alu_b   = s1_req.use_imm ? s1_req.imm : rt_data;

  always_ff @(posedge CLK) begin
    if (reset) begin
      rsp_valid_q <= 1'b0;
    end else if (advance) begin
      rsp_valid_q <= 1'b1;
    end else if (rsp_ready) begin
      rsp_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge CLK) begin
    if (advance) begin
      rsp_q.result <= alu_result;
      rsp_q.rd     <= s1_req.rd;
      rsp_q.flags  <= alu_flags;
    end
  end

  assign rsp_valid = rsp_valid_q;
  assign rsp       = rsp_q;

  // Writeback on the same edge that fills the response register
  assign wr_en   = advance;
  assign wr_addr = s1_req.rd;
  assign wr_data = alu_result;

endmodule

//--- src/register_file.sv
/*
  Register file
  32 x 32 with two combinational read ports and one write port,
  register 0 reads as zero
*/

`timescale 1ns/1ns

module register_file (
  input  logic                     CLK,
  input  logic                     reset,
  input  cpu_types_pkg::reg_addr_t rs_addr,
  input  cpu_types_pkg::reg_addr_t rt_addr,
  output cpu_types_pkg::word_t     rs_data,
  output cpu_types_pkg::word_t     rt_data,
  input  logic                     wr_en,
  input  cpu_types_pkg::reg_addr_t wr_addr,
  input  cpu_types_pkg::word_t     wr_data
);

  // Only registers 1 and up have storage
  cpu_types_pkg::word_t regs [1:cpu_types_pkg::REG_COUNT-1];

  always_ff @(posedge CLK) begin
    if (reset) begin
      for (int i = 1; i < cpu_types_pkg::REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en && (wr_addr != '0)) begin
      regs[wr_addr] <= wr_data;
    end
  end

  // Reads see the value before any write on the coming edge
  always_comb begin
    if (rs_addr == '0) begin
      rs_data = '0;
    end else begin
      rs_data = regs[rs_addr];
    end
  end

  always_comb begin
    if (rt_addr == '0) begin
      rt_data = '0;
    end else begin
      rt_data = regs[rt_addr];
    end
  end

endmodule

//--- tb/alu_exec_tb.sv
/*
  ALU execute slice testbench
  Directed and random requests with random response back-pressure,
  checked against a register-level reference model
*/

`timescale 1ns/1ns

module alu_exec_tb;

  localparam int          CLK_PERIOD   = 100;
  localparam int          RESET_CYCLES = 8;
  localparam logic [31:0] SEED         = 32'h8cbd329b;

  // Requests sent by each test phase
  localparam int N_RESET_READS = 32;
  localparam int N_DIRECTED    = 18;
  localparam int N_RAND_ARITH  = 40;
  localparam int N_RAND_LOGIC  = 80;
  localparam int N_ZERO_REG    = 4;
  localparam int N_CHAIN       = 20;
  localparam int N_BACKPRESS   = 120;
  localparam int N_REQ = N_RESET_READS + N_DIRECTED + N_RAND_ARITH + N_RAND_LOGIC
                       + N_ZERO_REG + N_CHAIN + N_BACKPRESS;
  localparam int WATCHDOG_CYCLES = N_REQ * 8 + 100;

  logic                     CLK;
  logic                     reset;
  logic                     req_valid;
  logic                     req_ready;
  cpu_types_pkg::exec_req_t req;
  logic                     rsp_valid;
  logic                     rsp_ready;
  cpu_types_pkg::exec_rsp_t rsp;

  // Reference model state
  cpu_types_pkg::word_t     model_regs [0:cpu_types_pkg::REG_COUNT-1];
  cpu_types_pkg::exec_rsp_t exp_q [$];
  int                       acc_q [$];

  logic                     bp_mode;
  logic                     any_accepted;
  logic                     prev_reset;
  logic                     stalled_prev;
  cpu_types_pkg::exec_rsp_t held_rsp;
  int                       cycle;
  int                       last_low_cycle;
  int                       n_accepted;
  int                       n_checks;
  int                       errors;

  alu_exec_top alu_exec_top_i (
    .CLK       (CLK),
    .reset     (reset),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .req       (req),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready),
    .rsp       (rsp)
  );

  always #(CLK_PERIOD / 2) CLK = ~CLK;

  // Expected response from the opcode rules
  function automatic cpu_types_pkg::exec_rsp_t model_op(
    input cpu_types_pkg::aluop_t    op,
    input cpu_types_pkg::word_t     a,
    input cpu_types_pkg::word_t     b,
    input cpu_types_pkg::reg_addr_t rd
  );
    cpu_types_pkg::exec_rsp_t r;
    logic [32:0]              wide;
    r.flags.overflow = 1'b0;
    case (op)
      cpu_types_pkg::ALU_SLL:  r.result = a << b[4:0];
      cpu_types_pkg::ALU_SRL:  r.result = a >> b[4:0];
      cpu_types_pkg::ALU_AND:  r.result = a & b;
      cpu_types_pkg::ALU_OR:   r.result = a | b;
      cpu_types_pkg::ALU_XOR:  r.result = a ^ b;
      cpu_types_pkg::ALU_NOR:  r.result = ~(a | b);
      cpu_types_pkg::ALU_SLT:  r.result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      cpu_types_pkg::ALU_SLTU: r.result = (a < b) ? 32'd1 : 32'd0;
      cpu_types_pkg::ALU_ADD: begin
        // Sign-extended sum leaves the 32-bit range when the top two bits differ
        wide             = {a[31], a} + {b[31], b};
        r.result         = wide[31:0];
        r.flags.overflow = wide[32] ^ wide[31];
      end
      cpu_types_pkg::ALU_SUB: begin
        wide             = {a[31], a} - {b[31], b};
        r.result         = wide[31:0];
        r.flags.overflow = wide[32] ^ wide[31];
      end
      default: r.result = '0;
    endcase
    r.flags.negative = r.result[31];
    r.flags.zero     = (r.result == '0);
    r.rd             = rd;
    return r;
  endfunction

  function automatic cpu_types_pkg::exec_req_t make_req(
    input cpu_types_pkg::aluop_t    op,
    input cpu_types_pkg::reg_addr_t rs,
    input cpu_types_pkg::reg_addr_t rt,
    input logic                     use_imm,
    input cpu_types_pkg::word_t     imm,
    input cpu_types_pkg::reg_addr_t rd
  );
    cpu_types_pkg::exec_req_t r;
    r.op      = op;
    r.rs      = rs;
    r.rt      = rt;
    r.use_imm = use_imm;
    r.imm     = imm;
    r.rd      = rd;
    return r;
  endfunction

  function automatic cpu_types_pkg::reg_addr_t random_reg();
    return cpu_types_pkg::reg_addr_t'($urandom % 32);
  endfunction

  function automatic cpu_types_pkg::aluop_t random_logic_op(input int sel);
    case (sel)
      0:       return cpu_types_pkg::ALU_SLL;
      1:       return cpu_types_pkg::ALU_SRL;
      2:       return cpu_types_pkg::ALU_AND;
      3:       return cpu_types_pkg::ALU_OR;
      4:       return cpu_types_pkg::ALU_XOR;
      5:       return cpu_types_pkg::ALU_NOR;
      6:       return cpu_types_pkg::ALU_SLT;
      default: return cpu_types_pkg::ALU_SLTU;
    endcase
  endfunction

  // Holds the request until the DUT takes it
  task automatic send_req(input cpu_types_pkg::exec_req_t r);
    @(negedge CLK);
    req_valid = 1'b1;
    req       = r;
    @(posedge CLK);
    while (!req_ready) begin
      @(posedge CLK);
    end
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(negedge CLK);
      req_valid = 1'b0;
    end
  endtask

  // Loads a and b into r1 and r2 through immediates, then r3 = r1 op r2
  task automatic arith_case(
    input cpu_types_pkg::aluop_t op,
    input cpu_types_pkg::word_t  a,
    input cpu_types_pkg::word_t  b
  );
    send_req(make_req(cpu_types_pkg::ALU_ADD, 5'd0, 5'd0, 1'b1, a, 5'd1));
    send_req(make_req(cpu_types_pkg::ALU_ADD, 5'd0, 5'd0, 1'b1, b, 5'd2));
    send_req(make_req(op, 5'd1, 5'd2, 1'b0, '0, 5'd3));
  endtask

  // Random back-pressure on the response port
  always @(negedge CLK) begin
    if (bp_mode) begin
      rsp_ready = ($urandom % 3) != 0;
    end else begin
      rsp_ready = 1'b1;
    end
  end

  // Monitor, reference model and checks
  always @(posedge CLK) begin
    cpu_types_pkg::exec_rsp_t expected;
    cpu_types_pkg::word_t     op_a;
    cpu_types_pkg::word_t     op_b;
    int                       acc_cycle;
    cycle++;
    if (reset) begin
      for (int i = 0; i < cpu_types_pkg::REG_COUNT; i++) begin
        model_regs[i] = '0;
      end
    end
    if (prev_reset || (!reset && !any_accepted)) begin
      assert (rsp_valid === 1'b0) else begin
        $display("Error at %0t: rsp_valid high before the first response", $time);
        errors++;
      end
    end
    if (!reset && stalled_prev) begin
      assert (rsp_valid === 1'b1 && rsp === held_rsp) else begin
        $display("Error at %0t: stalled response changed from %h to %h", $time,
                 held_rsp, rsp);
        errors++;
      end
    end
    if (!reset) begin
      // Only a full pipeline with an untaken response blocks a new request
      assert (req_ready === (rsp_ready || exp_q.size() < 2)) else begin
        $display("Error at %0t: req_ready %b with %0d in flight and rsp_ready %b", $time,
                 req_ready, exp_q.size(), rsp_ready);
        errors++;
      end
    end
    if (!reset && rsp_valid === 1'b1 && rsp_ready) begin
      assert (exp_q.size() != 0) else begin
        $display("Response at %0t arrived with no request outstanding", $time);
        errors++;
      end
      if (exp_q.size() != 0) begin
        expected  = exp_q.pop_front();
        acc_cycle = acc_q.pop_front();
        n_checks++;
        assert (rsp === expected) else begin
          $display("Error at %0t: rd %0d result %h flags %b, expected rd %0d result %h flags %b",
                   $time, rsp.rd, rsp.result, rsp.flags,
                   expected.rd, expected.result, expected.flags);
          errors++;
        end
        // Fixed latency holds only when rsp_ready never dropped since acceptance
        if (last_low_cycle <= acc_cycle) begin
          assert (cycle == acc_cycle + 2) else begin
            $display("Error at %0t: response took %0d cycles instead of 2", $time,
                     cycle - acc_cycle);
            errors++;
          end
        end
      end
    end
    if (!reset && req_valid && req_ready) begin
      any_accepted = 1'b1;
      n_accepted++;
      op_a = model_regs[req.rs];
      op_b = req.use_imm ? req.imm : model_regs[req.rt];
      expected = model_op(req.op, op_a, op_b, req.rd);
      if (req.rd != '0) begin
        model_regs[req.rd] = expected.result;
      end
      exp_q.push_back(expected);
      acc_q.push_back(cycle);
    end
    if (!reset && !rsp_ready) begin
      last_low_cycle = cycle;
    end
    stalled_prev = !reset && (rsp_valid === 1'b1) && !rsp_ready;
    held_rsp     = rsp;
    prev_reset   = reset;
  end

  initial begin
    #(CLK_PERIOD * WATCHDOG_CYCLES);
    $display("Timeout: the run did not finish within %0d cycles, the DUT looks hung",
             WATCHDOG_CYCLES);
    $display("CHECKS FAILED");
    $finish;
  end

  initial begin
    int waited;
    CLK            = 1'b0;
    reset          = 1'b1;
    req_valid      = 1'b0;
    req            = '0;
    rsp_ready      = 1'b1;
    bp_mode        = 1'b0;
    any_accepted   = 1'b0;
    prev_reset     = 1'b0;
    stalled_prev   = 1'b0;
    held_rsp       = '0;
    cycle          = 0;
    last_low_cycle = 0;
    n_accepted     = 0;
    n_checks       = 0;
    errors         = 0;
    waited         = 0;
    void'($urandom(SEED));

    repeat (RESET_CYCLES) @(posedge CLK);
    @(negedge CLK);
    reset = 1'b0;
    idle_cycles(3);

    // Every register reads zero after reset
    for (int r = 0; r < N_RESET_READS; r++) begin
      send_req(make_req(cpu_types_pkg::ALU_OR, cpu_types_pkg::reg_addr_t'(r), 5'd0,
                        1'b0, '0, 5'd0));
    end

    // ADD and SUB corner cases
    arith_case(cpu_types_pkg::ALU_ADD, 32'd40, 32'd50);
    arith_case(cpu_types_pkg::ALU_ADD, -32'd40, 32'd40);
    arith_case(cpu_types_pkg::ALU_ADD, 32'h7fff_ffff, 32'd1);
    arith_case(cpu_types_pkg::ALU_ADD, -32'd200, -32'd300);
    arith_case(cpu_types_pkg::ALU_SUB, -32'd1800000000, 32'd1800000001);
    arith_case(cpu_types_pkg::ALU_SUB, 32'd600, 32'd1000);

    for (int i = 0; i < N_RAND_ARITH; i++) begin
      send_req(make_req(($urandom % 2) == 1 ? cpu_types_pkg::ALU_SUB : cpu_types_pkg::ALU_ADD,
                        random_reg(), random_reg(), ($urandom % 2) == 1,
                        cpu_types_pkg::word_t'($urandom), random_reg()));
    end

    for (int i = 0; i < N_RAND_LOGIC; i++) begin
      send_req(make_req(random_logic_op($urandom % 8), random_reg(), random_reg(),
                        ($urandom % 2) == 1, cpu_types_pkg::word_t'($urandom),
                        random_reg()));
    end

    // Writes to r0 are dropped
    send_req(make_req(cpu_types_pkg::ALU_ADD, 5'd1, 5'd0, 1'b1, 32'h1234_5678, 5'd0));
    send_req(make_req(cpu_types_pkg::ALU_OR, 5'd0, 5'd0, 1'b0, '0, 5'd5));
    send_req(make_req(cpu_types_pkg::ALU_SUB, 5'd2, 5'd3, 1'b0, '0, 5'd0));
    send_req(make_req(cpu_types_pkg::ALU_ADD, 5'd0, 5'd0, 1'b1, 32'd0, 5'd6));

    // Dependent chain through r7
    for (int i = 0; i < N_CHAIN; i++) begin
      if (i % 4 == 3) begin
        send_req(make_req(cpu_types_pkg::ALU_ADD, 5'd7, 5'd7, 1'b0, '0, 5'd7));
      end else if (i % 4 == 2) begin
        send_req(make_req(cpu_types_pkg::ALU_SLL, 5'd7, 5'd0, 1'b1, 32'd1, 5'd7));
      end else begin
        send_req(make_req(cpu_types_pkg::ALU_SUB, 5'd7, 5'd0, 1'b1,
                          cpu_types_pkg::word_t'($urandom), 5'd7));
      end
    end

    bp_mode = 1'b1;
    for (int i = 0; i < N_BACKPRESS; i++) begin
      send_req(make_req(cpu_types_pkg::aluop_t'($urandom % 10), random_reg(), random_reg(),
                        ($urandom % 2) == 1, cpu_types_pkg::word_t'($urandom),
                        random_reg()));
    end
    bp_mode = 1'b0;

    idle_cycles(1);
    while (exp_q.size() != 0 && waited < 50) begin
      @(negedge CLK);
      waited++;
    end
    assert (exp_q.size() == 0) else begin
      $display("%0d accepted requests never received a response", exp_q.size());
      errors++;
    end

    $display("Requests accepted: %0d, responses checked: %0d, errors: %0d",
             n_accepted, n_checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule
